// File: include/core_defines.svh
`ifndef CORE_DEFINES_SVH
`define CORE_DEFINES_SVH

// Data word width
`define XLEN 32

// Architectural registers, x0 included
`define REG_COUNT 32

// First fetch address after reset
`define RESET_PC 32'h0000_0000

`endif

// File: design/isaPkg.sv
package isaPkg;

    // Major opcodes handled by this slice
    typedef enum logic [6:0] {
        opOp     = 7'b0110011,
        opImm    = 7'b0010011,
        opLoad   = 7'b0000011,
        opStore  = 7'b0100011,
        opBranch = 7'b1100011,
        opJal    = 7'b1101111,
        opJalr   = 7'b1100111,
        opLui    = 7'b0110111
    } opcode_t;

    typedef enum logic [3:0] {
        aluAdd,
        aluSub,
        aluAnd,
        aluOr,
        aluXor,
        aluSll,
        aluSrl,
        aluSra,
        aluSlt,
        aluSltu,
        aluPassB
    } aluOp_t;

    // funct3 of loads and stores
    typedef enum logic [2:0] {
        memByte      = 3'b000,
        memHalf      = 3'b001,
        memWord      = 3'b010,
        memByteU     = 3'b100,
        memHalfU     = 3'b101
    } memCtrl_t;

    // funct3 of branches
    typedef enum logic [2:0] {
        brEq  = 3'b000,
        brNe  = 3'b001,
        brLt  = 3'b100,
        brGe  = 3'b101,
        brLtu = 3'b110,
        brGeu = 3'b111
    } branchCond_t;

endpackage

// File: design/pipePkg.sv
package pipePkg;

    `include "core_defines.svh"

    typedef logic [`XLEN-1:0] word_t;

    typedef logic [$clog2(`REG_COUNT)-1:0] regAddr_t;

    // What goes back to the register file
    typedef enum logic [1:0] {
        resAlu     = 2'b00,
        resPcPlus4 = 2'b01,
        resMemory  = 2'b10
    } resultSrc_t;

endpackage

// File: design/decodeStage.sv
`timescale 1ns/1ps
`include "core_defines.svh"

module decodeStage import isaPkg::*, pipePkg::*; (
    input  logic        clk,
    input  logic        arstN,
    input  logic        instrValid,
    input  word_t       instr,
    input  word_t       instrPc,
    input  logic        regWriteW,
    input  regAddr_t    rdW,
    input  word_t       resultW,
    output logic        regWriteD,
    output resultSrc_t  resultSrcD,
    output logic        memWriteD,
    output logic        memReadD,
    output memCtrl_t    memCtrlD,
    output aluOp_t      aluOpD,
    output logic        aluSrcD,
    output logic        jumpD,
    output logic        branchD,
    output logic        jalrD,
    output branchCond_t branchCondD,
    output word_t       rd1D,
    output word_t       rd2D,
    output word_t       pcD,
    output word_t       pcPlus4D,
    output word_t       immExtD,
    output regAddr_t    rdD,
    output regAddr_t    rs1D,
    output regAddr_t    rs2D
);
    word_t      regFile [`REG_COUNT];
    opcode_t    opcode;
    logic [2:0] funct3;
    aluOp_t     fieldAluOp;

    assign opcode   = opcode_t'(instr[6:0]);
    assign funct3   = instr[14:12];
    assign rdD      = instr[11:7];
    assign rs1D     = instr[19:15];
    assign rs2D     = instr[24:20];
    assign pcD      = instrPc;
    assign pcPlus4D = instrPc + word_t'(4);

    // funct7 bit 5 picks sub and sra
    always_comb begin
        case (funct3)
            3'b000:  fieldAluOp = (opcode == opOp && instr[30]) ? aluSub : aluAdd;
            3'b001:  fieldAluOp = aluSll;
            3'b010:  fieldAluOp = aluSlt;
            3'b011:  fieldAluOp = aluSltu;
            3'b100:  fieldAluOp = aluXor;
            3'b101:  fieldAluOp = instr[30] ? aluSra : aluSrl;
            3'b110:  fieldAluOp = aluOr;
            default: fieldAluOp = aluAnd;
        endcase
    end

    always_comb begin
        regWriteD   = 1'b0;
        resultSrcD  = resAlu;
        memWriteD   = 1'b0;
        memReadD    = 1'b0;
        memCtrlD    = memByte;
        aluOpD      = aluAdd;
        aluSrcD     = 1'b0;
        jumpD       = 1'b0;
        branchD     = 1'b0;
        jalrD       = 1'b0;
        branchCondD = brEq;
        if (instrValid) begin
            case (opcode)
                opOp: begin
                    regWriteD = 1'b1;
                    aluOpD    = fieldAluOp;
                end
                opImm: begin
                    regWriteD = 1'b1;
                    aluOpD    = fieldAluOp;
                    aluSrcD   = 1'b1;
                end
                opLoad: begin
                    // Flagged as memory result, never written back
                    regWriteD  = 1'b1;
                    resultSrcD = resMemory;
                    memReadD   = 1'b1;
                    memCtrlD   = memCtrl_t'(funct3);
                    aluSrcD    = 1'b1;
                end
                opStore: begin
                    memWriteD = 1'b1;
                    memCtrlD  = memCtrl_t'(funct3);
                    aluSrcD   = 1'b1;
                end
                opBranch: begin
                    branchD     = 1'b1;
                    branchCondD = branchCond_t'(funct3);
                    aluOpD      = aluSub;
                end
                opJal: begin
                    regWriteD  = 1'b1;
                    resultSrcD = resPcPlus4;
                    jumpD      = 1'b1;
                end
                opJalr: begin
                    regWriteD  = 1'b1;
                    resultSrcD = resPcPlus4;
                    jalrD      = 1'b1;
                    aluSrcD    = 1'b1;
                end
                opLui: begin
                    regWriteD = 1'b1;
                    aluOpD    = aluPassB;
                    aluSrcD   = 1'b1;
                end
                default: ;
            endcase
        end
    end

    // Immediate by format, I-type when nothing else fits
    always_comb begin
        case (opcode)
            opStore:  immExtD = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            opBranch: immExtD = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
            opJal:    immExtD = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
            opLui:    immExtD = {instr[31:12], 12'b0};
            default:  immExtD = {{20{instr[31]}}, instr[31:20]};
        endcase
    end

    // x0 is never written so it reads back zero
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                regFile[i] <= '0;
            end
        end else if (regWriteW && rdW != '0) begin
            regFile[rdW] <= resultW;
        end
    end

    // Write-through for a register written this cycle
    assign rd1D = (regWriteW && rdW != '0 && rdW == rs1D) ? resultW : regFile[rs1D];
    assign rd2D = (regWriteW && rdW != '0 && rdW == rs2D) ? resultW : regFile[rs2D];

endmodule

// File: design/decodeExecuteReg.sv
`timescale 1ns/1ps
`include "core_defines.svh"

module decodeExecuteReg import isaPkg::*, pipePkg::*; (
    input  logic        clk,
    input  logic        arstN,
    input  logic        flushE,
    input  logic        regWriteD,
    input  resultSrc_t  resultSrcD,
    input  logic        memWriteD,
    input  logic        memReadD,
    input  memCtrl_t    memCtrlD,
    input  aluOp_t      aluOpD,
    input  logic        aluSrcD,
    input  logic        jumpD,
    input  logic        branchD,
    input  logic        jalrD,
    input  branchCond_t branchCondD,
    input  word_t       rd1D,
    input  word_t       rd2D,
    input  word_t       pcD,
    input  word_t       pcPlus4D,
    input  word_t       immExtD,
    input  regAddr_t    rdD,
    input  regAddr_t    rs1D,
    input  regAddr_t    rs2D,
    output logic        regWriteE,
    output resultSrc_t  resultSrcE,
    output logic        memWriteE,
    output logic        memReadE,
    output memCtrl_t    memCtrlE,
    output aluOp_t      aluOpE,
    output logic        aluSrcE,
    output logic        jumpE,
    output logic        branchE,
    output logic        jalrE,
    output branchCond_t branchCondE,
    output word_t       rd1E,
    output word_t       rd2E,
    output word_t       pcE,
    output word_t       pcPlus4E,
    output word_t       immExtE,
    output regAddr_t    rdE,
    output regAddr_t    rs1E,
    output regAddr_t    rs2E
);

    // Control, a bubble on reset or flush
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN || flushE) begin
            regWriteE   <= 1'b0;
            resultSrcE  <= resAlu;
            memWriteE   <= 1'b0;
            memReadE    <= 1'b0;
            memCtrlE    <= memByte;
            aluOpE      <= aluAdd;
            aluSrcE     <= 1'b0;
            jumpE       <= 1'b0;
            branchE     <= 1'b0;
            jalrE       <= 1'b0;
            branchCondE <= brEq;
        end else begin
            regWriteE   <= regWriteD;
            resultSrcE  <= resultSrcD;
            memWriteE   <= memWriteD;
            memReadE    <= memReadD;
            memCtrlE    <= memCtrlD;
            aluOpE      <= aluOpD;
            aluSrcE     <= aluSrcD;
            jumpE       <= jumpD;
            branchE     <= branchD;
            jalrE       <= jalrD;
            branchCondE <= branchCondD;
        end
    end

    // Operands and addresses; a flushed slot keeps them, control is off
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            rd1E     <= '0;
            rd2E     <= '0;
            pcE      <= `RESET_PC;
            pcPlus4E <= `RESET_PC + 4;
            immExtE  <= '0;
            rdE      <= '0;
            rs1E     <= '0;
            rs2E     <= '0;
        end else begin
            rd1E     <= rd1D;
            rd2E     <= rd2D;
            pcE      <= pcD;
            pcPlus4E <= pcPlus4D;
            immExtE  <= immExtD;
            rdE      <= rdD;
            rs1E     <= rs1D;
            rs2E     <= rs2D;
        end
    end

endmodule

// File: design/executeStage.sv
`timescale 1ns/1ps

module executeStage import isaPkg::*, pipePkg::*; (
    input  aluOp_t      aluOpE,
    input  logic        aluSrcE,
    input  logic        jumpE,
    input  logic        branchE,
    input  logic        jalrE,
    input  branchCond_t branchCondE,
    input  word_t       rd1E,
    input  word_t       rd2E,
    input  word_t       pcE,
    input  word_t       immExtE,
    input  regAddr_t    rs1E,
    input  regAddr_t    rs2E,
    input  logic        regWriteW,
    input  regAddr_t    rdW,
    input  word_t       resultW,
    output word_t       aluResultE,
    output word_t       writeDataE,
    output logic        redirect,
    output word_t       pcTarget
);
    logic  fwdA;
    logic  fwdB;
    word_t srcA;
    word_t regB;
    word_t srcB;
    logic  isEqual;
    logic  isLess;
    logic  isLessU;
    logic  taken;

    // Forward from the result register
    assign fwdA = regWriteW && rdW != '0 && rdW == rs1E;
    assign fwdB = regWriteW && rdW != '0 && rdW == rs2E;

    assign srcA       = fwdA ? resultW : rd1E;
    assign regB       = fwdB ? resultW : rd2E;
    assign srcB       = aluSrcE ? immExtE : regB;
    assign writeDataE = regB;

    always_comb begin
        case (aluOpE)
            aluAdd:   aluResultE = srcA + srcB;
            aluSub:   aluResultE = srcA - srcB;
            aluAnd:   aluResultE = srcA & srcB;
            aluOr:    aluResultE = srcA | srcB;
            aluXor:   aluResultE = srcA ^ srcB;
            aluSll:   aluResultE = srcA << srcB[4:0];
            aluSrl:   aluResultE = srcA >> srcB[4:0];
            aluSra:   aluResultE = word_t'($signed(srcA) >>> srcB[4:0]);
            aluSlt:   aluResultE = word_t'($signed(srcA) < $signed(srcB));
            aluSltu:  aluResultE = word_t'(srcA < srcB);
            aluPassB: aluResultE = srcB;
            default:  aluResultE = srcA + srcB;
        endcase
    end

    // Branch compare works on the two register operands
    assign isEqual = srcA == regB;
    assign isLess  = $signed(srcA) < $signed(regB);
    assign isLessU = srcA < regB;

    always_comb begin
        case (branchCondE)
            brEq:    taken = isEqual;
            brNe:    taken = !isEqual;
            brLt:    taken = isLess;
            brGe:    taken = !isLess;
            brLtu:   taken = isLessU;
            brGeu:   taken = !isLessU;
            default: taken = 1'b0;
        endcase
    end

    assign redirect = jumpE || jalrE || (branchE && taken);

    // JALR target drops bit 0
    assign pcTarget = jalrE ? ((srcA + immExtE) & ~word_t'(1)) : (pcE + immExtE);

endmodule

// File: design/resultReg.sv
`timescale 1ns/1ps

module resultReg import isaPkg::*, pipePkg::*; (
    input  logic       clk,
    input  logic       arstN,
    input  word_t      aluResultE,
    input  word_t      writeDataE,
    input  logic       regWriteE,
    input  resultSrc_t resultSrcE,
    input  logic       memWriteE,
    input  logic       memReadE,
    input  memCtrl_t   memCtrlE,
    input  regAddr_t   rdE,
    input  word_t      pcPlus4E,
    output logic       regWriteW,
    output regAddr_t   rdW,
    output word_t      resultW,
    output logic       memWriteW,
    output logic       memReadW,
    output memCtrl_t   memCtrlW,
    output word_t      memAddrW,
    output word_t      memDataW
);
    resultSrc_t resultSrcW;
    word_t      pcPlus4W;

    // No memory data path here, so a load never writes back
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            regWriteW <= 1'b0;
            memWriteW <= 1'b0;
            memReadW  <= 1'b0;
        end else begin
            regWriteW <= regWriteE && !memReadE;
            memWriteW <= memWriteE;
            memReadW  <= memReadE;
        end
    end

    always_ff @(posedge clk) begin
        rdW        <= rdE;
        resultSrcW <= resultSrcE;
        memCtrlW   <= memCtrlE;
        memAddrW   <= aluResultE;
        memDataW   <= writeDataE;
        pcPlus4W   <= pcPlus4E;
    end

    // Link address for jumps, ALU value otherwise
    assign resultW = (resultSrcW == resPcPlus4) ? pcPlus4W : memAddrW;

endmodule

// File: design/decodeExecuteCore.sv
`timescale 1ns/1ps

module decodeExecuteCore import isaPkg::*, pipePkg::*; (
    input  logic     clk,
    input  logic     arstN,
    input  logic     instrValid,
    input  word_t    instr,
    input  word_t    instrPc,
    output logic     redirect,
    output word_t    pcTarget,
    output logic     regWriteW,
    output regAddr_t rdW,
    output word_t    resultW,
    output logic     memWriteW,
    output logic     memReadW,
    output memCtrl_t memCtrlW,
    output word_t    memAddrW,
    output word_t    memDataW
);
    // Decode side
    logic        regWriteD, memWriteD, memReadD, aluSrcD, jumpD, branchD, jalrD;
    resultSrc_t  resultSrcD;
    memCtrl_t    memCtrlD;
    aluOp_t      aluOpD;
    branchCond_t branchCondD;
    word_t       rd1D, rd2D, pcD, pcPlus4D, immExtD;
    regAddr_t    rdD, rs1D, rs2D;

    // Execute side
    logic        regWriteE, memWriteE, memReadE, aluSrcE, jumpE, branchE, jalrE;
    resultSrc_t  resultSrcE;
    memCtrl_t    memCtrlE;
    aluOp_t      aluOpE;
    branchCond_t branchCondE;
    word_t       rd1E, rd2E, pcE, pcPlus4E, immExtE;
    regAddr_t    rdE, rs1E, rs2E;
    word_t       aluResultE, writeDataE;

    decodeStage i_decodeStage (.*);

    // A redirect squashes the instruction behind the jump
    decodeExecuteReg i_decodeExecuteReg (
        .flushE (redirect),
        .*
    );

    executeStage i_executeStage (.*);

    resultReg i_resultReg (.*);

endmodule

// File: sim/coreTb.sv
`timescale 1ns/1ps
`include "core_defines.svh"

module coreTb import isaPkg::*, pipePkg::*; ();

    typedef struct packed {
        int         due;
        logic       regWrite;
        regAddr_t   rd;
        word_t      result;
        logic       memWrite;
        logic       memRead;
        logic [2:0] memCtrl;
        word_t      memAddr;
        word_t      memData;
    } wbEntry_t;

    typedef struct packed {
        int    due;
        logic  taken;
        word_t target;
    } redirEntry_t;

    // addi x1, x1, 1 sits in slots that must never execute
    localparam word_t fillerInstr = 32'h0010_8093;

    logic     clk;
    logic     arstN;
    logic     instrValid;
    word_t    instr;
    word_t    instrPc;
    logic     redirect;
    word_t    pcTarget;
    logic     regWriteW;
    regAddr_t rdW;
    word_t    resultW;
    logic     memWriteW;
    logic     memReadW;
    memCtrl_t memCtrlW;
    word_t    memAddrW;
    word_t    memDataW;

    word_t       refRegs [`REG_COUNT];
    word_t       refPc;
    word_t       prog [$];
    wbEntry_t    wbQ [$];
    redirEntry_t redirQ [$];
    wbEntry_t    expWb;
    redirEntry_t expRed;
    word_t       lcgState;
    logic        checkOn;
    int          errors;
    int          cycle;
    int          cycleLimit = 1000;

    decodeExecuteCore i_decodeExecuteCore (.*);

    always #4 clk = ~clk;

    function automatic word_t nextRand();
        lcgState = lcgState * 32'd1664525 + 32'd1013904223;
        return lcgState;
    endfunction

    function automatic word_t encR(input logic [6:0] f7, input regAddr_t rs2, rs1,
                                   input logic [2:0] f3, input regAddr_t rd);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic word_t encI(input logic [11:0] imm, input regAddr_t rs1,
                                   input logic [2:0] f3, input regAddr_t rd,
                                   input logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic word_t encS(input logic [11:0] imm, input regAddr_t rs2, rs1,
                                   input logic [2:0] f3);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'b0100011};
    endfunction

    function automatic word_t encB(input logic [12:0] imm, input regAddr_t rs2, rs1,
                                   input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
    endfunction

    function automatic word_t encJ(input logic [20:0] imm, input regAddr_t rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
    endfunction

    // RV32I integer op by funct3, alt selects sub and sra
    function automatic word_t aluRef(input logic [2:0] f3, input logic alt,
                                     input word_t a, input word_t b);
        case (f3)
            3'b000:  return alt ? a - b : a + b;
            3'b001:  return a << b[4:0];
            3'b010:  return {31'b0, $signed(a) < $signed(b)};
            3'b011:  return {31'b0, a < b};
            3'b100:  return a ^ b;
            3'b101: begin
                if (alt) begin
                    return $signed(a) >>> b[4:0];
                end
                return a >> b[4:0];
            end
            3'b110:  return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic branchRef(input logic [2:0] f3, input word_t a, input word_t b);
        case (f3)
            3'b000:  return a == b;
            3'b001:  return a != b;
            3'b100:  return $signed(a) < $signed(b);
            3'b101:  return $signed(a) >= $signed(b);
            3'b110:  return a < b;
            default: return a >= b;
        endcase
    endfunction

    // Architectural step, queues what the ports must show and when
    task automatic execRef(input word_t ins, input int issueCyc,
                           output logic taken, output word_t nextPc);
        logic [2:0]  f3;
        word_t       a;
        word_t       b;
        word_t       immI;
        wbEntry_t    w;
        redirEntry_t r;
        f3     = ins[14:12];
        a      = refRegs[ins[19:15]];
        b      = refRegs[ins[24:20]];
        immI   = {{20{ins[31]}}, ins[31:20]};
        w      = '0;
        w.due  = issueCyc + 2;
        w.rd   = ins[11:7];
        taken  = 1'b0;
        nextPc = refPc + 4;
        case (ins[6:0])
            opOp: begin
                w.regWrite = 1'b1;
                w.result   = aluRef(f3, ins[30], a, b);
            end
            opImm: begin
                // funct7 only matters for the right shifts
                w.regWrite = 1'b1;
                w.result   = aluRef(f3, ins[30] && f3 == 3'b101, a, immI);
            end
            opLui: begin
                w.regWrite = 1'b1;
                w.result   = {ins[31:12], 12'b0};
            end
            opLoad: begin
                w.memRead = 1'b1;
                w.memCtrl = f3;
                w.memAddr = a + immI;
            end
            opStore: begin
                w.memWrite = 1'b1;
                w.memCtrl  = f3;
                w.memAddr  = a + {{20{ins[31]}}, ins[31:25], ins[11:7]};
                w.memData  = b;
            end
            opBranch: begin
                taken = branchRef(f3, a, b);
                if (taken) begin
                    nextPc = refPc + {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
                end
            end
            opJal: begin
                taken      = 1'b1;
                nextPc     = refPc + {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
                w.regWrite = 1'b1;
                w.result   = refPc + 4;
            end
            opJalr: begin
                taken      = 1'b1;
                nextPc     = (a + immI) & ~word_t'(1);
                w.regWrite = 1'b1;
                w.result   = refPc + 4;
            end
            default: begin
                errors++;
                $display("Program table holds an unsupported opcode %h", ins[6:0]);
            end
        endcase
        if (w.regWrite && w.rd != '0) begin
            refRegs[w.rd] = w.result;
        end
        if (w.regWrite || w.memRead || w.memWrite) begin
            wbQ.push_back(w);
        end
        if (taken) begin
            r.due    = issueCyc + 1;
            r.taken  = 1'b1;
            r.target = nextPc;
            redirQ.push_back(r);
        end
    endtask

    task automatic issueInstr(input word_t ins);
        logic  taken;
        word_t nextPc;
        @(posedge clk);
        #1;
        instrValid = 1'b1;
        instr      = ins;
        instrPc    = refPc;
        execRef(ins, cycle, taken, nextPc);
        if (taken) begin
            // Fall-through slot, the redirect must squash it
            @(posedge clk);
            #1;
            instr   = fillerInstr;
            instrPc = refPc + 4;
        end
        refPc = nextPc;
    endtask

    task automatic idleCycle();
        @(posedge clk);
        #1;
        instrValid = 1'b0;
        instr      = fillerInstr;
    endtask

    task automatic buildProgram();
        word_t rnd;
        rnd = nextRand();
        prog.push_back({rnd[31:12], 5'd1, 7'b0110111});
        rnd = nextRand();
        prog.push_back(encI({1'b0, rnd[30:20]}, 5'd0, 3'b000, 5'd2, opImm));
        prog.push_back(encI(12'hffb, 5'd0, 3'b000, 5'd3, opImm));
        prog.push_back(encR(7'h00, 5'd2, 5'd1, 3'b000, 5'd4));
        prog.push_back(encR(7'h20, 5'd3, 5'd4, 3'b000, 5'd5));
        prog.push_back(encR(7'h00, 5'd1, 5'd5, 3'b111, 5'd6));
        prog.push_back(encR(7'h00, 5'd2, 5'd6, 3'b110, 5'd7));
        prog.push_back(encR(7'h00, 5'd5, 5'd7, 3'b100, 5'd8));
        prog.push_back(encR(7'h00, 5'd3, 5'd2, 3'b001, 5'd9));
        prog.push_back(encR(7'h00, 5'd2, 5'd3, 3'b101, 5'd10));
        prog.push_back(encR(7'h20, 5'd2, 5'd3, 3'b101, 5'd11));
        rnd = nextRand();
        prog.push_back(encI({7'h20, rnd[28:24]}, 5'd3, 3'b101, 5'd12, opImm));
        prog.push_back(encI(12'h003, 5'd8, 3'b001, 5'd13, opImm));
        prog.push_back(encR(7'h00, 5'd2, 5'd3, 3'b010, 5'd14));
        prog.push_back(encR(7'h00, 5'd2, 5'd3, 3'b011, 5'd15));
        prog.push_back(encI(12'h001, 5'd3, 3'b010, 5'd16, opImm));
        prog.push_back(encI(12'hfff, 5'd2, 3'b011, 5'd17, opImm));
        rnd = nextRand();
        prog.push_back(encI(rnd[31:20], 5'd1, 3'b100, 5'd18, opImm));
        prog.push_back(encI(12'h0f0, 5'd18, 3'b110, 5'd19, opImm));
        prog.push_back(encI(12'h7ff, 5'd19, 3'b111, 5'd20, opImm));
        // x0 target, then read back at distance 1
        prog.push_back(encI(12'h007, 5'd1, 3'b000, 5'd0, opImm));
        prog.push_back(encR(7'h00, 5'd1, 5'd0, 3'b000, 5'd21));
        prog.push_back(encS(12'h00c, 5'd5, 5'd1, 3'b010));
        prog.push_back(encS(12'hffd, 5'd2, 5'd4, 3'b000));
        prog.push_back(encS(12'h002, 5'd21, 5'd2, 3'b001));
        prog.push_back(encI(12'h004, 5'd1, 3'b010, 5'd9, opLoad));
        prog.push_back(encR(7'h00, 5'd0, 5'd9, 3'b000, 5'd22));
        prog.push_back(encI(12'hffe, 5'd2, 3'b100, 5'd10, opLoad));
        prog.push_back(encI(12'h010, 5'd3, 3'b101, 5'd11, opLoad));
        prog.push_back(encB(13'd8, 5'd2, 5'd2, 3'b000));
        prog.push_back(encI(12'h001, 5'd22, 3'b000, 5'd23, opImm));
        prog.push_back(encB(13'd8, 5'd2, 5'd2, 3'b001));
        prog.push_back(encB(13'd12, 5'd2, 5'd3, 3'b100));
        prog.push_back(encB(13'h1ff0, 5'd2, 5'd3, 3'b110));
        prog.push_back(encB(13'h1ff0, 5'd3, 5'd2, 3'b110));
        prog.push_back(encB(13'd16, 5'd2, 5'd3, 3'b101));
        prog.push_back(encB(13'd16, 5'd3, 5'd2, 3'b111));
        prog.push_back(encJ(21'd16, 5'd24));
        prog.push_back(encI(12'h004, 5'd24, 3'b000, 5'd25, opImm));
        // Odd target, bit 0 gets cleared
        prog.push_back(encI(12'h005, 5'd24, 3'b000, 5'd26, opJalr));
        prog.push_back(encI(12'h000, 5'd26, 3'b000, 5'd26, opJalr));
        prog.push_back(encR(7'h00, 5'd26, 5'd25, 3'b000, 5'd27));
        prog.push_back(encJ(21'h1ffff8, 5'd0));
        prog.push_back(encR(7'h00, 5'd27, 5'd23, 3'b100, 5'd28));
    endtask

    task automatic reportMismatch(input string what, input word_t got, input word_t want);
        errors++;
        $display("MISMATCH at %0t ns: %s is %h, expected %h", $time, what, got, want);
    endtask

    // Expectation for the cycle now running
    always @(negedge clk) begin
        expWb  = '0;
        expRed = '0;
        if (wbQ.size() > 0 && wbQ[0].due == cycle) begin
            expWb = wbQ.pop_front();
        end
        if (redirQ.size() > 0 && redirQ[0].due == cycle) begin
            expRed = redirQ.pop_front();
        end
    end

    assert property (@(posedge clk) !checkOn || regWriteW === expWb.regWrite)
        else reportMismatch("regWriteW", word_t'($sampled(regWriteW)), word_t'(expWb.regWrite));
    assert property (@(posedge clk) !checkOn || !expWb.regWrite || rdW === expWb.rd)
        else reportMismatch("rdW", word_t'($sampled(rdW)), word_t'(expWb.rd));
    assert property (@(posedge clk) !checkOn || !expWb.regWrite || resultW === expWb.result)
        else reportMismatch("resultW", $sampled(resultW), expWb.result);
    assert property (@(posedge clk) !checkOn || memWriteW === expWb.memWrite)
        else reportMismatch("memWriteW", word_t'($sampled(memWriteW)), word_t'(expWb.memWrite));
    assert property (@(posedge clk) !checkOn || memReadW === expWb.memRead)
        else reportMismatch("memReadW", word_t'($sampled(memReadW)), word_t'(expWb.memRead));
    assert property (@(posedge clk)
        !checkOn || !(expWb.memWrite || expWb.memRead) || memAddrW === expWb.memAddr)
        else reportMismatch("memAddrW", $sampled(memAddrW), expWb.memAddr);
    assert property (@(posedge clk)
        !checkOn || !(expWb.memWrite || expWb.memRead) || memCtrlW === expWb.memCtrl)
        else reportMismatch("memCtrlW", word_t'($sampled(memCtrlW)), word_t'(expWb.memCtrl));
    assert property (@(posedge clk) !checkOn || !expWb.memWrite || memDataW === expWb.memData)
        else reportMismatch("memDataW", $sampled(memDataW), expWb.memData);
    assert property (@(posedge clk) !checkOn || redirect === expRed.taken)
        else reportMismatch("redirect", word_t'($sampled(redirect)), word_t'(expRed.taken));
    assert property (@(posedge clk) !checkOn || !expRed.taken || pcTarget === expRed.target)
        else reportMismatch("pcTarget", $sampled(pcTarget), expRed.target);

    always @(posedge clk) begin
        cycle++;
        if (cycle > cycleLimit) begin
            $display("Timeout: the run did not finish within %0d cycles", cycleLimit);
            $display("Result: FAILED");
            $finish;
        end
    end

    initial begin
        clk        = 1'b0;
        arstN      = 1'b0;
        instrValid = 1'b0;
        instr      = '0;
        instrPc    = `RESET_PC;
        checkOn    = 1'b0;
        errors     = 0;
        cycle      = 0;
        lcgState   = 32'd6;
        refPc      = `RESET_PC;
        expWb      = '0;
        expRed     = '0;
        for (int i = 0; i < `REG_COUNT; i++) begin
            refRegs[i] = '0;
        end
        buildProgram();
        cycleLimit = 2 * prog.size() + 50;

        repeat (3) @(posedge clk);
        #1;
        arstN   = 1'b1;
        checkOn = 1'b1;
        idleCycle();
        idleCycle();

        for (int i = 0; i < prog.size(); i++) begin
            // One bubble from a low valid inside the stream
            if (i == 8) begin
                idleCycle();
            end
            issueInstr(prog[i]);
        end
        idleCycle();

        while (wbQ.size() != 0 || redirQ.size() != 0) begin
            @(posedge clk);
        end
        @(posedge clk);
        #1;

        $display("Checks failed: %0d", errors);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

// File: build.f
+incdir+include
design/isaPkg.sv
design/pipePkg.sv
design/decodeStage.sv
design/decodeExecuteReg.sv
design/executeStage.sv
design/resultReg.sv
design/decodeExecuteCore.sv
sim/coreTb.sv

// File: run.sh
#!/bin/sh
# Build the testbench with Verilator and run it
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal \
    --timescale 1ns/1ps \
    --top-module coreTb \
    -f build.f \
    -o coreSim

./obj_dir/coreSim > sim.log
cat sim.log

if grep -q "Result: PASSED" sim.log; then
    echo "Simulation passed"
else
    echo "Simulation failed"
    exit 1
fi
